//--- common/fetch_pkg.sv
package fetch_pkg;

    localparam int INST_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int BUF_DEPTH = 16;

    // enough bits to count 0..BUF_DEPTH
    localparam int COUNT_W   = $clog2(BUF_DEPTH + 1);

    // one instruction
    typedef logic [INST_W-1:0] inst_t;

    // byte address or pc
    typedef logic [ADDR_W-1:0] addr_t;

    // bus word, lower-address instruction in the low half
    typedef logic [2*INST_W-1:0] fetch_word_t;

    // buffer occupancy
    typedef logic [COUNT_W-1:0] count_t;

    localparam addr_t RESET_PC = 32'h0000_1000;

    // bus side of the fetch unit
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_BUS  = 2'd1,
        FETCH_HOLD = 2'd2
    } fetch_state_t;

endpackage

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   redirect,
    input  fetch_pkg::addr_t       redirect_pc,
    input  logic                   almost_full,
    input  logic                   resp_accept,
    input  fetch_pkg::fetch_word_t wb_dat_i,
    input  logic                   wb_ack,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output fetch_pkg::addr_t       wb_adr,
    output logic                   resp_valid,
    output fetch_pkg::addr_t       resp_pc,
    output fetch_pkg::fetch_word_t resp_data,
    output logic                   resp_two
);

    fetch_pkg::fetch_state_t state_q;
    fetch_pkg::addr_t        pc_q;
    fetch_pkg::addr_t        adr_q;
    fetch_pkg::fetch_word_t  data_q;
    logic                    discard_q;
    logic                    start_read;
    logic                    bus_done;
    fetch_pkg::addr_t        pc_next_line;

    // start a read only when there is room and no redirect this cycle
    assign start_read = (state_q == fetch_pkg::FETCH_IDLE) && !redirect && !almost_full;
    assign bus_done   = (state_q == fetch_pkg::FETCH_BUS) && wb_ack;

    // next 8-byte boundary after the current pc
    assign pc_next_line = {pc_q[31:3] + 29'd1, 3'b000};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= fetch_pkg::FETCH_IDLE;
            pc_q      <= fetch_pkg::RESET_PC;
            discard_q <= 1'b0;
        end else begin
            case (state_q)
                fetch_pkg::FETCH_IDLE: begin
                    if (redirect) begin
                        pc_q <= redirect_pc;
                    end else if (!almost_full) begin
                        state_q <= fetch_pkg::FETCH_BUS;
                    end
                end
                fetch_pkg::FETCH_BUS: begin
                    if (redirect) begin
                        pc_q <= redirect_pc;
                    end
                    if (wb_ack) begin
                        discard_q <= 1'b0;
                        // stale data goes nowhere, back to idle
                        if (discard_q || redirect) begin
                            state_q <= fetch_pkg::FETCH_IDLE;
                        end else begin
                            state_q <= fetch_pkg::FETCH_HOLD;
                        end
                    end else if (redirect) begin
                        discard_q <= 1'b1;
                    end
                end
                fetch_pkg::FETCH_HOLD: begin
                    if (redirect) begin
                        pc_q    <= redirect_pc;
                        state_q <= fetch_pkg::FETCH_IDLE;
                    end else if (resp_accept) begin
                        pc_q    <= pc_next_line;
                        state_q <= fetch_pkg::FETCH_IDLE;
                    end
                end
                default: begin
                    state_q <= fetch_pkg::FETCH_IDLE;
                end
            endcase
        end
    end

    // address is frozen for the whole bus cycle
    always_ff @(posedge clk) begin
        if (start_read) begin
            adr_q <= {pc_q[31:3], 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (bus_done) begin
            data_q <= wb_dat_i;
        end
    end

    assign wb_cyc = (state_q == fetch_pkg::FETCH_BUS);
    assign wb_stb = (state_q == fetch_pkg::FETCH_BUS);
    assign wb_we  = 1'b0;
    assign wb_adr = adr_q;

    assign resp_valid = (state_q == fetch_pkg::FETCH_HOLD);
    assign resp_pc    = pc_q;
    assign resp_data  = data_q;
    // upper word only when pc sits on bit 2
    assign resp_two   = ~pc_q[2];

endmodule

//--- fetch_buffer/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   take0,
    input  logic                   take1,
    input  logic                   resp_valid,
    input  fetch_pkg::addr_t       resp_pc,
    input  fetch_pkg::fetch_word_t resp_data,
    input  logic                   resp_two,
    output logic                   resp_accept,
    output logic                   almost_full,
    output fetch_pkg::inst_t       ir0,
    output fetch_pkg::addr_t       pc0,
    output logic                   valid0,
    output fetch_pkg::inst_t       ir1,
    output fetch_pkg::addr_t       pc1,
    output logic                   valid1
);

    // slot 0 always holds the oldest instruction
    fetch_pkg::inst_t  inst_q [fetch_pkg::BUF_DEPTH];
    fetch_pkg::addr_t  pc_q   [fetch_pkg::BUF_DEPTH];
    fetch_pkg::count_t count_q;

    logic              push;
    logic [1:0]        n_pop;
    logic [1:0]        n_push;
    fetch_pkg::count_t keep;
    fetch_pkg::count_t count_next;
    fetch_pkg::inst_t  new_ir0;
    fetch_pkg::inst_t  new_ir1;
    fetch_pkg::addr_t  new_pc0;
    fetch_pkg::addr_t  new_pc1;

    assign valid0 = (count_q != '0);
    assign valid1 = (count_q > fetch_pkg::count_t'(1));

    assign resp_accept = ~stall & ~flush;
    assign push        = resp_valid & resp_accept;

    // take1 only counts together with take0, and only for valid slots
    always_comb begin
        n_pop = 2'd0;
        if (!stall && !flush && take0 && valid0) begin
            if (take1 && valid1) begin
                n_pop = 2'd2;
            end else begin
                n_pop = 2'd1;
            end
        end
    end

    assign n_push = push ? (resp_two ? 2'd2 : 2'd1) : 2'd0;

    // entries that survive the pop
    assign keep       = count_q - fetch_pkg::count_t'(n_pop);
    assign count_next = keep + fetch_pkg::count_t'(n_push);

    // single instruction pairs start at the high half
    assign new_ir0 = resp_two ? resp_data[31:0] : resp_data[63:32];
    assign new_ir1 = resp_data[63:32];
    assign new_pc0 = resp_pc;
    assign new_pc1 = resp_pc + 32'd4;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count_q <= '0;
        end else if (flush) begin
            count_q <= '0;
        end else if (!stall) begin
            count_q <= count_next;
        end
    end

    // shift down by n_pop, append new entries behind the survivors
    always_ff @(posedge clk) begin
        if (n_pop != 2'd0 || push) begin
            for (int i = 0; i < fetch_pkg::BUF_DEPTH; i++) begin
                if (push && fetch_pkg::count_t'(i) == keep) begin
                    inst_q[i] <= new_ir0;
                    pc_q[i]   <= new_pc0;
                end else if (push && resp_two &&
                             fetch_pkg::count_t'(i) == keep + fetch_pkg::count_t'(1)) begin
                    inst_q[i] <= new_ir1;
                    pc_q[i]   <= new_pc1;
                end else if (i + int'(n_pop) < fetch_pkg::BUF_DEPTH) begin
                    inst_q[i] <= inst_q[i + int'(n_pop)];
                    pc_q[i]   <= pc_q[i + int'(n_pop)];
                end
            end
        end
    end

    // fetch may still have one pair in flight, so leave two slots
    assign almost_full = (count_q > fetch_pkg::count_t'(fetch_pkg::BUF_DEPTH - 2));

    assign ir0 = inst_q[0];
    assign pc0 = pc_q[0];
    assign ir1 = inst_q[1];
    assign pc1 = pc_q[1];

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   redirect,
    input  fetch_pkg::addr_t       redirect_pc,
    input  logic                   stall,
    input  logic                   take0,
    input  logic                   take1,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output fetch_pkg::addr_t       wb_adr,
    input  fetch_pkg::fetch_word_t wb_dat_i,
    input  logic                   wb_ack,
    output fetch_pkg::inst_t       ir0,
    output fetch_pkg::addr_t       pc0,
    output logic                   valid0,
    output fetch_pkg::inst_t       ir1,
    output fetch_pkg::addr_t       pc1,
    output logic                   valid1
);

    // response handoff between fetch and buffer
    logic                   resp_valid;
    fetch_pkg::addr_t       resp_pc;
    fetch_pkg::fetch_word_t resp_data;
    logic                   resp_two;
    logic                   resp_accept;
    logic                   almost_full;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .almost_full (almost_full),
        .resp_accept (resp_accept),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .resp_valid  (resp_valid),
        .resp_pc     (resp_pc),
        .resp_data   (resp_data),
        .resp_two    (resp_two)
    );

    fetch_buffer i_fetch_buffer (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (redirect),
        .stall       (stall),
        .take0       (take0),
        .take1       (take1),
        .resp_valid  (resp_valid),
        .resp_pc     (resp_pc),
        .resp_data   (resp_data),
        .resp_two    (resp_two),
        .resp_accept (resp_accept),
        .almost_full (almost_full),
        .ir0         (ir0),
        .pc0         (pc0),
        .valid0      (valid0),
        .ir1         (ir1),
        .pc1         (pc1),
        .valid1      (valid1)
    );

endmodule

//--- bench/wb_rom_model.sv
`timescale 1ns/1ps

module wb_rom_model (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  fetch_pkg::addr_t       adr,
    output fetch_pkg::fetch_word_t dat,
    output logic                   ack
);

    logic [1:0] wait_left;
    logic       busy;

    // instruction at byte address a is the bitwise not of a
    function automatic fetch_pkg::inst_t rom_word(input fetch_pkg::addr_t a);
        return ~a;
    endfunction

    // lower address in the low half
    assign dat = {rom_word(adr + 32'd4), rom_word(adr)};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack       <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 2'd0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !we && !ack) begin
                if (!busy) begin
                    // 0 to 3 wait states per request
                    wait_left <= 2'($urandom);
                    busy      <= 1'b1;
                end else if (wait_left == 2'd0) begin
                    ack  <= 1'b1;
                    busy <= 1'b0;
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

endmodule

//--- bench/fetch_properties.sv
`timescale 1ns/1ps

module fetch_properties (
    input logic             clk,
    input logic             rstn,
    input logic             redirect,
    input logic             stall,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_ack,
    input fetch_pkg::addr_t wb_adr,
    input logic             valid0,
    input logic             valid1,
    input fetch_pkg::inst_t ir0,
    input fetch_pkg::addr_t pc0,
    input fetch_pkg::addr_t pc1
);

    // classic cycle ends in the cycle after ack
    cyc_stb_drop: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |=> !wb_cyc && !wb_stb)
        else $error("wb_cyc or wb_stb still high after ack");

    adr_aligned: assert property (@(posedge clk) disable iff (!rstn)
        wb_cyc |-> wb_adr[2:0] == 3'b000)
        else $error("bus address not 8-byte aligned");

    // master holds the request until ack
    adr_stable: assert property (@(posedge clk) disable iff (!rstn)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
        else $error("bus request changed before ack");

    valid_order: assert property (@(posedge clk) disable iff (!rstn)
        valid1 |-> valid0 && pc1 == pc0 + 32'd4)
        else $error("valid1 without valid0 or pc1 out of order");

    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        stall && !redirect |=> $stable(valid0) && $stable(valid1) &&
                               $stable(ir0) && $stable(pc0))
        else $error("buffer outputs moved during stall");

endmodule

bind fetch_top fetch_properties i_fetch_properties (
    .clk      (clk),
    .rstn     (rstn),
    .redirect (redirect),
    .stall    (stall),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .wb_adr   (wb_adr),
    .valid0   (valid0),
    .valid1   (valid1),
    .ir0      (ir0),
    .pc0      (pc0),
    .pc1      (pc1)
);

//--- bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int NUM_TESTS     = 8;
    localparam int RESET_TIMEOUT = 50;
    localparam int FULL_WINDOW   = 40;

    localparam logic [1:0] TAKE_NONE      = 2'd0;
    localparam logic [1:0] TAKE_SINGLE    = 2'd1;
    localparam logic [1:0] TAKE_DUAL      = 2'd2;
    localparam logic [1:0] TAKE_RANDOM    = 2'd3;
    localparam logic [1:0] STALL_NONE     = 2'd0;
    localparam logic [1:0] STALL_PERIODIC = 2'd1;
    localparam logic [1:0] STALL_RANDOM   = 2'd2;

    typedef struct packed {
        logic [1:0]  take_mode;
        logic [1:0]  stall_mode;
        logic        do_redirect;
        logic [31:0] target;
        logic [15:0] cycles;
        logic [15:0] min_taken;
    } scenario_t;

    logic                   clk;
    logic                   rstn;
    logic                   redirect;
    fetch_pkg::addr_t       redirect_pc;
    logic                   stall;
    logic                   take0;
    logic                   take1;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    fetch_pkg::addr_t       wb_adr;
    fetch_pkg::fetch_word_t wb_dat_i;
    logic                   wb_ack;
    fetch_pkg::inst_t       ir0;
    fetch_pkg::addr_t       pc0;
    logic                   valid0;
    fetch_pkg::inst_t       ir1;
    fetch_pkg::addr_t       pc1;
    logic                   valid1;

    scenario_t        scenarios [NUM_TESTS];
    string            names [NUM_TESTS];
    fetch_pkg::addr_t expected_pc;
    int               error_count;
    int               check_count;
    int               row_taken;

    fetch_top i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .take0       (take0),
        .take1       (take1),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .ir0         (ir0),
        .pc0         (pc0),
        .valid0      (valid0),
        .ir1         (ir1),
        .pc1         (pc1),
        .valid1      (valid1)
    );

    wb_rom_model i_rom (
        .clk  (clk),
        .rstn (rstn),
        .cyc  (wb_cyc),
        .stb  (wb_stb),
        .we   (wb_we),
        .adr  (wb_adr),
        .dat  (wb_dat_i),
        .ack  (wb_ack)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic take_instruction(input fetch_pkg::addr_t pc, input fetch_pkg::inst_t ir);
        check_value("pc", pc, expected_pc);
        check_value("ir", ir, ~expected_pc);
        // next instruction in program order
        expected_pc = expected_pc + 32'd4;
        row_taken++;
    endtask

    task automatic load_scenarios();
        names[0] = "single takes";
        names[1] = "dual takes";
        names[2] = "no takes until full";
        names[3] = "resume after full";
        names[4] = "periodic stall";
        names[5] = "random stall";
        names[6] = "redirect to upper word";
        names[7] = "redirect with random traffic";
        scenarios[0] = '{TAKE_SINGLE, STALL_NONE, 1'b0, 32'h0, 16'd120, 16'd20};
        scenarios[1] = '{TAKE_DUAL, STALL_NONE, 1'b0, 32'h0, 16'd120, 16'd30};
        scenarios[2] = '{TAKE_NONE, STALL_NONE, 1'b0, 32'h0, 16'd160, 16'd0};
        scenarios[3] = '{TAKE_DUAL, STALL_NONE, 1'b0, 32'h0, 16'd120, 16'd30};
        scenarios[4] = '{TAKE_RANDOM, STALL_PERIODIC, 1'b0, 32'h0, 16'd150, 16'd10};
        scenarios[5] = '{TAKE_DUAL, STALL_RANDOM, 1'b0, 32'h0, 16'd150, 16'd10};
        scenarios[6] = '{TAKE_SINGLE, STALL_NONE, 1'b1, 32'h0000_2404, 16'd120, 16'd15};
        scenarios[7] = '{TAKE_RANDOM, STALL_RANDOM, 1'b1, 32'h0000_0800, 16'd150, 16'd10};
    endtask

    task automatic run_scenario(input int idx);
        scenario_t        sc;
        int               errors_before;
        logic             bus_seen;
        logic             redirect_done;
        logic             hold_pending;
        logic             flush_pending;
        fetch_pkg::inst_t snap_ir;
        fetch_pkg::addr_t snap_pc;
        logic             snap_v0;
        logic             snap_v1;
        sc = scenarios[idx];
        errors_before = error_count;
        row_taken = 0;
        bus_seen = 1'b0;
        redirect_done = 1'b0;
        hold_pending = 1'b0;
        flush_pending = 1'b0;
        for (int c = 0; c < int'(sc.cycles); c++) begin
            @(posedge clk);
            case (sc.take_mode)
                TAKE_NONE: begin
                    take0 <= 1'b0;
                    take1 <= 1'b0;
                end
                TAKE_SINGLE: begin
                    take0 <= 1'b1;
                    take1 <= 1'b0;
                end
                TAKE_DUAL: begin
                    take0 <= 1'b1;
                    take1 <= 1'b1;
                end
                default: begin
                    take0 <= 1'($urandom);
                    take1 <= 1'($urandom);
                end
            endcase
            case (sc.stall_mode)
                STALL_PERIODIC: stall <= (c % 8 >= 5);
                STALL_RANDOM:   stall <= ($urandom % 4 == 0);
                default:        stall <= 1'b0;
            endcase
            if (sc.do_redirect && bus_seen && !redirect_done) begin
                redirect      <= 1'b1;
                redirect_pc   <= sc.target;
                redirect_done = 1'b1;
            end else begin
                redirect <= 1'b0;
            end

            // outputs are settled here, the driven inputs act at the next edge
            @(negedge clk);
            if (flush_pending) begin
                check_value("valid0", 32'(valid0), 32'h0);
                check_value("valid1", 32'(valid1), 32'h0);
                flush_pending = 1'b0;
            end
            if (hold_pending) begin
                check_value("ir0", ir0, snap_ir);
                check_value("pc0", pc0, snap_pc);
                check_value("valid0", 32'(valid0), 32'(snap_v0));
                check_value("valid1", 32'(valid1), 32'(snap_v1));
                hold_pending = 1'b0;
            end
            // second slot follows the expected head
            if (valid1) begin
                check_value("pc1", pc1, expected_pc + 32'd4);
            end
            if (redirect) begin
                expected_pc   = sc.target;
                flush_pending = 1'b1;
            end else if (!stall && take0 && valid0) begin
                take_instruction(pc0, ir0);
                if (take1 && valid1) begin
                    take_instruction(pc1, ir1);
                end
            end
            if (stall && !redirect) begin
                snap_ir      = ir0;
                snap_pc      = pc0;
                snap_v0      = valid0;
                snap_v1      = valid1;
                hold_pending = 1'b1;
            end
            if (sc.take_mode == TAKE_NONE && c >= int'(sc.cycles) - FULL_WINDOW) begin
                check_value("wb_cyc", 32'(wb_cyc), 32'h0);
            end
            if (c >= 5 && wb_cyc && !wb_ack) begin
                bus_seen = 1'b1;
            end
        end

        if (sc.do_redirect && !redirect_done) begin
            $display("test %0d: no bus read was seen, the redirect was never issued", idx);
            error_count++;
        end
        if (row_taken < int'(sc.min_taken)) begin
            $display("test %0d: only %0d instructions taken, at least %0d expected",
                     idx, row_taken, sc.min_taken);
            error_count++;
        end
        if (sc.take_mode == TAKE_NONE) begin
            check_value("pc0", pc0, expected_pc);
            check_value("valid1", 32'(valid1), 32'h1);
        end
        $display("test %0d %s: %s, %0d taken", idx, names[idx],
                 (error_count == errors_before) ? "ok" : "FAILED", row_taken);
    endtask

    initial begin
        int waited;
        int errors_before;
        void'($urandom(77));
        clk         = 1'b0;
        rstn        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        take0       = 1'b0;
        take1       = 1'b0;
        error_count = 0;
        check_count = 0;
        row_taken   = 0;
        expected_pc = fetch_pkg::RESET_PC;
        load_scenarios();

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        errors_before = error_count;
        check_value("valid0", 32'(valid0), 32'h0);
        check_value("valid1", 32'(valid1), 32'h0);
        check_value("wb_cyc", 32'(wb_cyc), 32'h0);
        waited = 0;
        while (!valid0 && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!valid0) begin
            $display("timeout: valid0 never rose after reset");
            error_count++;
        end else begin
            check_value("pc0", pc0, fetch_pkg::RESET_PC);
            check_value("ir0", ir0, ~fetch_pkg::RESET_PC);
        end
        $display("test reset: %s", (error_count == errors_before) ? "ok" : "FAILED");

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_scenario(t);
        end

        $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS + 1, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/fetch_pkg.sv
source/fetch_unit.sv
fetch_buffer/fetch_buffer.sv
source/fetch_top.sv
bench/wb_rom_model.sv
bench/fetch_properties.sv
bench/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module fetch_tb -f verilog.f -o fetch_sim \
    > sim.log 2>&1 \
    && ./obj_dir/fetch_sim >> sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
